//--- compile.f
rtl/obi_pkg.sv
rtl/obi_rchk_check.sv
rtl/obi_integrity_fifo.sv
rtl/data_obi_interface.sv
rtl/data_obi_top.sv
verif/data_obi_tb.sv

//--- run_verilator.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" \
  && verilator --binary --timing -j 0 -f compile.f \
       --top-module data_obi_tb -o data_obi_sim \
  && ./obj_dir/data_obi_sim | tee /dev/stderr | grep -q "^PASS: all tests$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- verif/data_obi_tb.sv
// Data-side OBI testbench with bus responder, stimulus table, compare tasks and watchdog
`default_nettype none

module data_obi_tb;

  import obi_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DLY      = 5;
  localparam int SAMPLE_DLY     = 15;
  localparam int NUM_ROWS       = 12;
  localparam int CYCLES_PER_ROW = 20;

  // One stimulus row in the same field order as the add_row concatenation
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [2:0]  prot;
    logic [1:0]  memtype;
    logic        dbg;
    logic        integrity;
    logic [2:0]  gnt_dly;
    logic        err;
    logic        exokay;
    logic        bad_gntpar;
    logic        bad_rvalidpar;
    logic        flip_rchk;
    logic        rchk_en;
    logic        gntpar_chk_en;
    logic        stray;
    // Leave the response outstanding until the next row is granted
    logic        defer;
  } row_t;

  // Response the responder still owes and what the core side should see
  typedef struct packed {
    obi_bus_resp_t  bus;
    logic           bad_rvp;
    obi_data_resp_t exp;
    logic           exp_ierr;
  } pend_t;

  logic               clk;
  logic               arst_n;
  logic               trans_valid;
  logic               trans_ready;
  obi_data_req_t      trans;
  logic               resp_valid;
  obi_data_resp_t     resp;
  logic               integrity_err;
  logic               protocol_err;
  obi_xsecure_ctrl_t  xsecure_ctrl;
  obi_req_strobe_t    obi_req;
  obi_data_req_t      obi_req_payload;
  obi_gnt_strobe_t    obi_gnt;
  obi_rvalid_strobe_t obi_rvalid;
  obi_bus_resp_t      obi_resp;

  row_t               rows [NUM_ROWS];
  int                 row_cnt;
  logic [31:0]        rand_wdata [NUM_ROWS];
  logic [31:0]        rand_rdata [NUM_ROWS];
  integer             seed;
  pend_t              pend_q [$];

  data_obi_top i_dut (
    .clk               (clk),
    .arst_n_i          (arst_n),
    .trans_valid_i     (trans_valid),
    .trans_ready_o     (trans_ready),
    .trans_i           (trans),
    .resp_valid_o      (resp_valid),
    .resp_o            (resp),
    .integrity_err_o   (integrity_err),
    .protocol_err_o    (protocol_err),
    .xsecure_ctrl_i    (xsecure_ctrl),
    .obi_req_o         (obi_req),
    .obi_req_payload_o (obi_req_payload),
    .obi_gnt_i         (obi_gnt),
    .obi_rvalid_i      (obi_rvalid),
    .obi_resp_i        (obi_resp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference parity
  ////////////////////////////////////////////////////////////////////////////

  // wdata bytes on top and addr bytes at the bottom
  function automatic logic [OBI_ACHK_W-1:0] calc_achk(input obi_data_req_t r);
    logic [OBI_ACHK_W-1:0] c;
    c = '0;
    for (int b = 0; b < 4; b++) begin
      c[8 + b] = ^r.wdata[8*b +: 8];
      c[b]     = ^r.addr[8*b +: 8];
    end
    // Bit 7 is the atop bit and stays zero
    c[6] = ~r.dbg;
    c[5] = ~(^{r.be, r.we});
    c[4] = ~(^{r.prot, r.memtype});
    return c;
  endfunction

  function automatic logic [OBI_RCHK_W-1:0] calc_rchk(input logic [31:0] rdata,
                                                      input logic err, input logic exokay);
    logic [OBI_RCHK_W-1:0] c;
    for (int b = 0; b < 4; b++) begin
      c[1 + b] = ^rdata[8*b +: 8];
    end
    c[0] = ~(err ^ exokay);
    return c;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_req(input string name, input obi_data_req_t exp, input obi_data_req_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch at time %0t: %s expected %h actual %h",
                              $time, name, exp, act));
    end
  endtask

  task automatic check_strobe(input string name, input obi_req_strobe_t exp,
                              input obi_req_strobe_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch at time %0t: %s expected %b actual %b",
                              $time, name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input obi_data_resp_t exp,
                            input obi_data_resp_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch at time %0t: %s expected %h actual %h",
                              $time, name, exp, act));
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch at time %0t: %s expected %b actual %b",
                              $time, name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Responder model
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_cycle;
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  // attr is {prot, memtype, dbg}
  // resp_st is {err, exokay}
  // flags is {bad_gntpar, bad_rvalidpar, flip_rchk, rchk_en, gntpar_chk_en, stray, defer}
  task automatic add_row(input logic [31:0] addr, input logic we, input logic [3:0] be,
                         input logic [5:0] attr, input logic integ, input logic [2:0] dly,
                         input logic [1:0] resp_st, input logic [6:0] flags);
    rows[row_cnt] = {addr, we, be, attr, integ, dly, resp_st, flags};
    row_cnt = row_cnt + 1;
  endtask

  // Send every owed response in order at one per cycle
  task automatic drain_responses;
    pend_t p;
    while (pend_q.size() > 0) begin
      p = pend_q.pop_front();
      obi_rvalid = {1'b1, p.bad_rvp};
      obi_resp   = p.bus;
      #(SAMPLE_DLY);
      check_err("resp_valid_o", 1'b1, resp_valid);
      check_resp("resp_o", p.exp, resp);
      check_err("integrity_err_o", p.exp_ierr, integrity_err);
      check_err("protocol_err_o", 1'b0, protocol_err);
      check_strobe("obi_req_o", 2'b01, obi_req);
      next_cycle();
      obi_rvalid = 2'b01;
    end
  endtask

  initial begin : main
    row_t          r;
    obi_data_req_t req;
    obi_data_req_t exp_req;
    pend_t         p;
    logic [2:0]    wait_cnt;
    logic          granted;
    logic          gnt_now;
    logic          rchk_err;
    logic          gp_err;

    clk          = 1'b0;
    arst_n       = 1'b0;
    trans_valid  = 1'b0;
    trans        = '0;
    xsecure_ctrl = 2'b11;
    // Idle strobes carry their inverted parity
    obi_gnt      = 2'b01;
    obi_rvalid   = 2'b01;
    obi_resp     = '0;
    row_cnt      = 0;
    seed         = 33970;

    //      addr          we    be    attr        int   dly   e/x    flags
    add_row(32'h0000_1000, 1'b0, 4'hf, 6'b000_00_0, 1'b1, 3'd0, 2'b00, 7'b000_11_0_0);
    add_row(32'h0000_2004, 1'b1, 4'h3, 6'b011_01_0, 1'b1, 3'd2, 2'b00, 7'b000_11_0_0);
    add_row(32'h8000_0010, 1'b1, 4'hc, 6'b101_10_1, 1'b1, 3'd1, 2'b01, 7'b001_11_0_0);
    add_row(32'h1234_5678, 1'b0, 4'hf, 6'b111_11_0, 1'b1, 3'd0, 2'b00, 7'b001_11_0_0);
    add_row(32'h0bad_cafe, 1'b0, 4'h1, 6'b010_00_0, 1'b1, 3'd1, 2'b00, 7'b001_01_0_0);
    add_row(32'h7fff_fffc, 1'b0, 4'hf, 6'b001_11_1, 1'b0, 3'd0, 2'b10, 7'b001_11_0_0);
    add_row(32'h0000_3000, 1'b0, 4'hf, 6'b000_01_0, 1'b1, 3'd3, 2'b00, 7'b100_11_0_1);
    add_row(32'h0000_3004, 1'b1, 4'hf, 6'b000_01_0, 1'b0, 3'd0, 2'b00, 7'b000_11_0_0);
    add_row(32'hdead_beef, 1'b0, 4'h6, 6'b100_10_0, 1'b0, 3'd1, 2'b01, 7'b010_11_0_0);
    add_row(32'h0000_4000, 1'b0, 4'hf, 6'b000_00_0, 1'b1, 3'd0, 2'b10, 7'b000_11_1_0);
    add_row(32'h0000_5000, 1'b1, 4'hf, 6'b110_11_1, 1'b1, 3'd0, 2'b01, 7'b101_10_0_1);
    add_row(32'h0000_5008, 1'b0, 4'hf, 6'b000_00_0, 1'b1, 3'd0, 2'b00, 7'b001_10_0_0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      rand_wdata[i] = $random(seed);
      rand_rdata[i] = $random(seed);
    end

    repeat (3) @(posedge clk);
    #(DRIVE_DLY);
    arst_n = 1'b1;
    next_cycle();

    for (int i = 0; i < NUM_ROWS; i++) begin
      r            = rows[i];
      xsecure_ctrl = {r.rchk_en, r.gntpar_chk_en};

      // Response with nothing outstanding
      if (r.stray) begin
        obi_rvalid = 2'b10;
        obi_resp   = {rand_rdata[i], 1'b0, 1'b0, calc_rchk(rand_rdata[i], 1'b0, 1'b0)};
        #(SAMPLE_DLY);
        check_err("protocol_err_o", 1'b1, protocol_err);
        check_err("integrity_err_o", 1'b0, integrity_err);
        next_cycle();
        obi_rvalid = 2'b01;
      end

      req.addr      = r.addr;
      req.we        = r.we;
      req.be        = r.be;
      req.wdata     = rand_wdata[i];
      req.prot      = r.prot;
      req.memtype   = r.memtype;
      req.dbg       = r.dbg;
      req.integrity = r.integrity;
      // Core-side achk is junk that the adapter must replace
      req.achk      = rand_wdata[i][11:0];
      exp_req       = req;
      exp_req.achk  = calc_achk(req);
      trans         = req;
      trans_valid   = 1'b1;

      // Hold gnt low for the row's delay and then grant
      wait_cnt = 3'd0;
      granted  = 1'b0;
      while (!granted) begin
        gnt_now        = (wait_cnt == r.gnt_dly);
        obi_gnt.gnt    = gnt_now;
        obi_gnt.gntpar = gnt_now ? r.bad_gntpar : 1'b1;
        #(SAMPLE_DLY);
        check_req("obi_req_payload_o", exp_req, obi_req_payload);
        check_strobe("obi_req_o", 2'b10, obi_req);
        check_err("trans_ready_o", gnt_now, trans_ready);
        check_err("integrity_err_o", gnt_now && r.bad_gntpar && r.gntpar_chk_en,
                  integrity_err);
        check_err("protocol_err_o", 1'b0, protocol_err);
        check_err("resp_valid_o", 1'b0, resp_valid);
        granted  = trans_ready;
        wait_cnt = wait_cnt + 3'd1;
        next_cycle();
      end
      trans_valid = 1'b0;
      obi_gnt     = 2'b01;

      // rchk bit 4 covers rdata byte 3 and is ignored on writes
      rchk_err        = r.flip_rchk && !r.we && r.rchk_en && r.integrity;
      gp_err          = r.bad_gntpar && r.gntpar_chk_en;
      p.bus.rdata     = rand_rdata[i];
      p.bus.err       = r.err;
      p.bus.exokay    = r.exokay;
      p.bus.rchk      = calc_rchk(rand_rdata[i], r.err, r.exokay) ^ {r.flip_rchk, 4'b0000};
      p.bad_rvp       = r.bad_rvalidpar;
      p.exp.rdata     = rand_rdata[i];
      p.exp.err       = r.err;
      p.exp.exokay    = r.exokay;
      p.exp.integrity = r.integrity;
      p.exp.integrity_err = r.bad_rvalidpar || gp_err || rchk_err;
      p.exp_ierr      = r.bad_rvalidpar || rchk_err;
      pend_q.push_back(p);

      if (!r.defer) begin
        drain_responses();
      end
    end

    $display("PASS: all tests");
    $finish;
  end

  // Bounds the run by the table length
  initial begin : watchdog
    #((NUM_ROWS * CYCLES_PER_ROW + 3) * CLK_PERIOD);
    stop_on_error("Timeout: the stimulus table did not finish in the allowed time");
  end

endmodule

`default_nettype wire

//--- rtl/data_obi_top.sv
// Data-side OBI subsystem top wrapping the bus adapter
`default_nettype none

module data_obi_top (
  input  logic                        clk,
  input  logic                        arst_n_i,

  // Load/store unit request
  input  logic                        trans_valid_i,
  output logic                        trans_ready_o,
  input  obi_pkg::obi_data_req_t      trans_i,

  // Load/store unit response
  output logic                        resp_valid_o,
  output obi_pkg::obi_data_resp_t     resp_o,

  // Error indications towards alert logic
  output logic                        integrity_err_o,
  output logic                        protocol_err_o,

  input  obi_pkg::obi_xsecure_ctrl_t  xsecure_ctrl_i,

  // OBI bus
  output obi_pkg::obi_req_strobe_t    obi_req_o,
  output obi_pkg::obi_data_req_t      obi_req_payload_o,
  input  obi_pkg::obi_gnt_strobe_t    obi_gnt_i,
  input  obi_pkg::obi_rvalid_strobe_t obi_rvalid_i,
  input  obi_pkg::obi_bus_resp_t      obi_resp_i
);

  import obi_pkg::*;

  // Record sized for the default number of in-flight accesses
  data_obi_interface #(
    .MAX_OUTSTANDING (OBI_MAX_OUTSTANDING)
  ) u_data_obi_interface (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .trans_valid_i     (trans_valid_i),
    .trans_ready_o     (trans_ready_o),
    .trans_i           (trans_i),
    .resp_valid_o      (resp_valid_o),
    .resp_o            (resp_o),
    .integrity_err_o   (integrity_err_o),
    .protocol_err_o    (protocol_err_o),
    .xsecure_ctrl_i    (xsecure_ctrl_i),
    .obi_req_o         (obi_req_o),
    .obi_req_payload_o (obi_req_payload_o),
    .obi_gnt_i         (obi_gnt_i),
    .obi_rvalid_i      (obi_rvalid_i),
    .obi_resp_i        (obi_resp_i)
  );

endmodule

`default_nettype wire

//--- rtl/data_obi_interface.sv
// Data-side OBI adapter with achk generation, strobe parity checks and core response forming
`default_nettype none

module data_obi_interface #(
  parameter int unsigned MAX_OUTSTANDING = obi_pkg::OBI_MAX_OUTSTANDING
) (
  input  logic                        clk,
  input  logic                        arst_n_i,

  // Core side request
  input  logic                        trans_valid_i,
  output logic                        trans_ready_o,
  input  obi_pkg::obi_data_req_t      trans_i,

  // Core side response, consumer is always ready
  output logic                        resp_valid_o,
  output obi_pkg::obi_data_resp_t     resp_o,

  output logic                        integrity_err_o,
  output logic                        protocol_err_o,

  input  obi_pkg::obi_xsecure_ctrl_t  xsecure_ctrl_i,

  // Bus side
  output obi_pkg::obi_req_strobe_t    obi_req_o,
  output obi_pkg::obi_data_req_t      obi_req_payload_o,
  input  obi_pkg::obi_gnt_strobe_t    obi_gnt_i,
  input  obi_pkg::obi_rvalid_strobe_t obi_rvalid_i,
  input  obi_pkg::obi_bus_resp_t      obi_resp_i
);

  import obi_pkg::*;

  // Request check word for the current payload
  logic [OBI_ACHK_W-1:0] achk;

  // Immediate strobe parity errors
  logic                  gntpar_err;
  logic                  rvalidpar_err;

  // Outputs of the transaction record
  logic                  gntpar_err_resp;
  logic                  integrity_resp;
  logic                  rchk_err_resp;

  ////////////////////////////////////////////////////////////////////////////
  // Request channel
  ////////////////////////////////////////////////////////////////////////////

  // Core holds the request stable until granted, so pass it straight through
  // wdata bytes, atop, dbg, be+we, prot+memtype, addr bytes
  assign achk = {
    ^trans_i.wdata[31:24],
    ^trans_i.wdata[23:16],
    ^trans_i.wdata[15:8],
    ^trans_i.wdata[7:0],
    1'b0,
    ~^trans_i.dbg,
    ~^{trans_i.be, trans_i.we},
    ~^{trans_i.prot, trans_i.memtype},
    ^trans_i.addr[31:24],
    ^trans_i.addr[23:16],
    ^trans_i.addr[15:8],
    ^trans_i.addr[7:0]
  };

  always_comb begin
    obi_req_payload_o      = trans_i;
    obi_req_payload_o.achk = achk;
  end

  assign obi_req_o.req    = trans_valid_i;
  assign obi_req_o.reqpar = ~trans_valid_i;

  assign trans_ready_o = obi_gnt_i.gnt;

  ////////////////////////////////////////////////////////////////////////////
  // Strobe parity
  ////////////////////////////////////////////////////////////////////////////

  // Parity equal to its strobe is an error
  assign gntpar_err    = (obi_gnt_i.gnt == obi_gnt_i.gntpar) && xsecure_ctrl_i.gntpar_chk_en;
  assign rvalidpar_err = (obi_rvalid_i.rvalid == obi_rvalid_i.rvalidpar);

  // Record keeps per-transaction flags until the response
  obi_integrity_fifo #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_obi_integrity_fifo (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .gntpar_err_i      (gntpar_err),
    .trans_integrity_i (trans_i.integrity),
    .trans_we_i        (trans_i.we),
    .xsecure_ctrl_i    (xsecure_ctrl_i),
    .obi_req_i         (obi_req_o.req),
    .obi_gnt_i         (obi_gnt_i.gnt),
    .obi_rvalid_i      (obi_rvalid_i.rvalid),
    .obi_resp_i        (obi_resp_i),
    .gntpar_err_resp_o (gntpar_err_resp),
    .integrity_resp_o  (integrity_resp),
    .rchk_err_resp_o   (rchk_err_resp),
    .protocol_err_o    (protocol_err_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Response channel
  ////////////////////////////////////////////////////////////////////////////

  assign resp_valid_o = obi_rvalid_i.rvalid;

  // rchk is consumed here, integrity result goes in its place
  assign resp_o.rdata         = obi_resp_i.rdata;
  assign resp_o.err           = obi_resp_i.err;
  assign resp_o.exokay        = obi_resp_i.exokay;
  assign resp_o.integrity_err = rvalidpar_err || gntpar_err_resp || rchk_err_resp;
  assign resp_o.integrity     = integrity_resp;

  // Grant parity shows up right away, response errors in the rvalid cycle
  assign integrity_err_o = rchk_err_resp || rvalidpar_err || gntpar_err;

endmodule

`default_nettype wire

//--- rtl/obi_integrity_fifo.sv
// Outstanding transaction record with response-time integrity outputs and protocol error
`default_nettype none

module obi_integrity_fifo #(
  parameter int unsigned MAX_OUTSTANDING = obi_pkg::OBI_MAX_OUTSTANDING
) (
  input  logic                      clk,
  input  logic                      arst_n_i,

  // Grant parity error of the current cycle
  input  logic                      gntpar_err_i,

  // Attributes of the request being granted
  input  logic                      trans_integrity_i,
  input  logic                      trans_we_i,

  input  obi_pkg::obi_xsecure_ctrl_t xsecure_ctrl_i,

  // Bus strobes and response
  input  logic                      obi_req_i,
  input  logic                      obi_gnt_i,
  input  logic                      obi_rvalid_i,
  input  obi_pkg::obi_bus_resp_t    obi_resp_i,

  // Results aligned to the response
  output logic                      gntpar_err_resp_o,
  output logic                      integrity_resp_o,
  output logic                      rchk_err_resp_o,

  output logic                      protocol_err_o
);

  // Pointer needs at least one bit even for a single entry
  localparam int unsigned PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  // Occupancy counts 0 up to MAX_OUTSTANDING
  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  // What is kept per outstanding transaction
  typedef struct packed {
    logic gntpar_err;
    logic integrity;
    logic we;
  } fifo_entry_t;

  fifo_entry_t             mem_q [MAX_OUTSTANDING];
  fifo_entry_t             wr_entry;
  fifo_entry_t             rd_entry;

  logic [PTR_W-1:0]        wptr_q;
  logic [PTR_W-1:0]        rptr_q;
  logic [CNT_W-1:0]        cnt_q;

  logic                    empty;
  logic                    full;
  logic                    push;
  logic                    pop;
  logic                    rchk_err;

  ////////////////////////////////////////////////////////////////////////////
  // Push and pop
  ////////////////////////////////////////////////////////////////////////////

  assign empty = (cnt_q == '0);
  assign full  = (cnt_q == CNT_W'(MAX_OUTSTANDING));

  // Response retires the oldest entry
  assign pop = obi_rvalid_i && !empty;

  // Granted request, room made by a same-cycle pop counts
  assign push = obi_req_i && obi_gnt_i && (!full || pop);

  assign wr_entry.gntpar_err = gntpar_err_i;
  assign wr_entry.integrity  = trans_integrity_i;
  assign wr_entry.we         = trans_we_i;

  // Oldest entry, read combinationally in the rvalid cycle
  assign rd_entry = mem_q[rptr_q];

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wptr_q] <= wr_entry;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wptr_q + PTR_W'(1);
      end
      if (pop) begin
        rptr_q <= (rptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rptr_q + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - CNT_W'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response-time results
  ////////////////////////////////////////////////////////////////////////////

  // Write data is undefined so only reads check rdata
  obi_rchk_check u_obi_rchk_check (
    .resp_i        (obi_resp_i),
    .check_rdata_i (!rd_entry.we),
    .rchk_err_o    (rchk_err)
  );

  // Recorded flags only leave with a matching response
  assign gntpar_err_resp_o = pop && rd_entry.gntpar_err;
  assign integrity_resp_o  = pop && rd_entry.integrity;

  // rchk only applies to integrity regions with checking enabled
  assign rchk_err_resp_o = pop && rd_entry.integrity && xsecure_ctrl_i.rchk_en && rchk_err;

  // Stray response, or a grant that cannot be recorded
  assign protocol_err_o = (obi_rvalid_i && empty) ||
                          (obi_req_i && obi_gnt_i && full && !pop);

endmodule

`default_nettype wire

//--- rtl/obi_rchk_check.sv
// Response check word calculation and compare against the received rchk
`default_nettype none

module obi_rchk_check (
  // Response as received from the bus
  input  obi_pkg::obi_bus_resp_t resp_i,
  // Set for reads, rdata of a write carries no meaning
  input  logic                   check_rdata_i,
  output logic                   rchk_err_o
);

  import obi_pkg::*;

  // Expected check word
  logic [OBI_RCHK_W-1:0] rchk_exp;
  // Bits that take part in the compare
  logic [OBI_RCHK_W-1:0] rchk_mask;
  // Mismatching bits
  logic [OBI_RCHK_W-1:0] rchk_diff;

  ////////////////////////////////////////////////////////////////////////////
  // Expected rchk
  ////////////////////////////////////////////////////////////////////////////

  // Upper four bits are even parity per rdata byte
  // Bit 0 is odd parity over err and exokay
  assign rchk_exp = {
    ^resp_i.rdata[31:24],
    ^resp_i.rdata[23:16],
    ^resp_i.rdata[15:8],
    ^resp_i.rdata[7:0],
    ~^{resp_i.err, resp_i.exokay}
  };

  ////////////////////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////////////////////

  // Data parity bits only count on reads
  // Status bit is always compared
  assign rchk_mask = {{(OBI_RCHK_W - 1){check_rdata_i}}, 1'b1};

  assign rchk_diff = (rchk_exp ^ resp_i.rchk) & rchk_mask;

  // Any masked mismatch is an error
  assign rchk_err_o = |rchk_diff;

endmodule

`default_nettype wire

//--- rtl/obi_pkg.sv
// OBI widths, request/response payload structs, strobe structs and security control struct
`default_nettype none

package obi_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Byte address, 32 bit data bus
  localparam int unsigned OBI_ADDR_W = 32;
  localparam int unsigned OBI_DATA_W = 32;

  // One byte enable per data byte
  localparam int unsigned OBI_BE_W = 4;

  // Request check word
  // 4 wdata bytes, atop, dbg, be+we, prot+memtype, 4 addr bytes
  localparam int unsigned OBI_ACHK_W = 12;

  // Response check word
  // 4 rdata bytes plus err+exokay
  localparam int unsigned OBI_RCHK_W = 5;

  // Default depth of the outstanding transaction record
  localparam int unsigned OBI_MAX_OUTSTANDING = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Request channel
  ////////////////////////////////////////////////////////////////////////////

  // Request payload, shared by core side and bus side
  // On the bus side achk is filled in by the adapter
  typedef struct packed {
    logic [OBI_ADDR_W-1:0] addr;
    logic                  we;
    logic [OBI_BE_W-1:0]   be;
    logic [OBI_DATA_W-1:0] wdata;
    // Privilege/security attributes
    logic [2:0]            prot;
    // Cacheable and bufferable
    logic [1:0]            memtype;
    // Access made in debug mode
    logic                  dbg;
    // Target region is integrity protected
    logic                  integrity;
    logic [OBI_ACHK_W-1:0] achk;
  } obi_data_req_t;

  // Request strobe with its inverted parity
  typedef struct packed {
    logic req;
    logic reqpar;
  } obi_req_strobe_t;

  // Grant strobe from the bus, gntpar expected as ~gnt
  typedef struct packed {
    logic gnt;
    logic gntpar;
  } obi_gnt_strobe_t;

  ////////////////////////////////////////////////////////////////////////////
  // Response channel
  ////////////////////////////////////////////////////////////////////////////

  // Response valid strobe, rvalidpar expected as ~rvalid
  typedef struct packed {
    logic rvalid;
    logic rvalidpar;
  } obi_rvalid_strobe_t;

  // Response as seen on the bus
  typedef struct packed {
    logic [OBI_DATA_W-1:0] rdata;
    logic                  err;
    logic                  exokay;
    logic [OBI_RCHK_W-1:0] rchk;
  } obi_bus_resp_t;

  // Response towards the core, rchk replaced by the integrity result
  typedef struct packed {
    logic [OBI_DATA_W-1:0] rdata;
    logic                  err;
    logic                  exokay;
    // Any parity or rchk error tied to this response
    logic                  integrity_err;
    // Integrity flag recorded with the request
    logic                  integrity;
  } obi_data_resp_t;

  ////////////////////////////////////////////////////////////////////////////
  // Security control
  ////////////////////////////////////////////////////////////////////////////

  // Static enables, rvalid parity has no enable
  typedef struct packed {
    logic rchk_en;
    logic gntpar_chk_en;
  } obi_xsecure_ctrl_t;

endpackage

`default_nettype wire
